// ==== verilog/minimig_defs.svh ====
/*
 * width and size macros for the memory and system-control core
 * include wherever a width or the reset counter size is needed
 */
`ifndef MINIMIG_DEFS_SVH
`define MINIMIG_DEFS_SVH

//------------------------------
// bus widths
//------------------------------

// bus and sram data word
`define MM_DATA_BITS 16

// 512 KB blocks behind the two sram banks
`define MM_NUM_BLOCKS 4

//------------------------------
// reset sequencer
//------------------------------

// hold ends when the top bit sets
// board value is 24, 6 keeps simulation short
`define MM_RST_CNT_BITS 6

`endif

// ==== verilog/minimig_pkg.sv ====
/*
 * shared types for the memory core: block names, memory configuration,
 * bus cycle kind and sequencer state. import with minimig_pkg::*
 */
`default_nettype none

`include "minimig_defs.svh"

package minimig_pkg;

	//------------------------------
	// sram block mapping
	//------------------------------

	// the four 512 KB blocks, bank 0 holds chip, bank 1 slow and kick
	typedef enum logic [1:0] {
		bank_chip_lo = 2'd0,	// chip 0..512K
		bank_chip_hi = 2'd1,	// chip 512K..1M
		bank_slow    = 2'd2,	// slow ram
		bank_kick    = 2'd3	// kickstart area
	} bank_e;

	// one enable per block, indexed by bank_e
	typedef logic [`MM_NUM_BLOCKS-1:0] bank_en_t;

	// bit 0 extra chip, bit 1 extra slow
	typedef enum logic [1:0] {
		mem_chip512         = 2'b00,
		mem_chip1m          = 2'b01,
		mem_chip512_slow512 = 2'b10,
		mem_chip1m_slow512  = 2'b11
	} memcfg_e;

	//------------------------------
	// bus and sequencer
	//------------------------------

	typedef enum logic [1:0] {cyc_idle, cyc_read, cyc_write} cyc_e;

	typedef enum logic {seq_hold, seq_run} seq_e;	// reset counting / running

	typedef logic [`MM_DATA_BITS-1:0] sram_data_t;

endpackage

`default_nettype wire

// ==== verilog/sram_req_if.sv ====
/*
 * decoded sram request, bank decoder to strobe bridge
 * plain levels, valid for as long as the bus master holds them
 */
`default_nettype none

interface sram_req_if
	import minimig_pkg::*;
();

	bank_en_t   aen;	// block enables, one hot or zero
	cyc_e       cyc;	// idle when nothing is addressed
	logic       hwr;	// upper byte write
	logic       lwr;	// lower byte write
	sram_data_t wdata;	// write data toward the sram

	// decoder side
	modport decoder
	(
		output aen, cyc, hwr, lwr, wdata
	);

	// bridge side
	modport bridge
	(
		input aen, cyc, hwr, lwr, wdata
	);

endinterface

`default_nettype wire

// ==== verilog/sys_control.sv ====
/*
 * boot and reset sequencer. holds sys_reset for a fixed count after
 * bootrst, a synchronized mrst or the bootdone exit, and keeps the
 * bootrom overlay on until the boot firmware reports done
 */
`default_nettype none

`include "minimig_defs.svh"

module sys_control
	import minimig_pkg::*;
(
	input  logic clk,
	input  logic bootrst,	// restart with boot overlay on
	input  logic mrst,	// user or keyboard reset level
	input  logic bootdone,	// pulse from boot firmware
	output logic sys_reset,	// global synchronous reset
	output logic boot	// bootrom overlay enable
);

	seq_e                        state;	// hold while counting
	logic                        mrst_s;	// mrst after one flop
	logic [`MM_RST_CNT_BITS-1:0] rst_cnt;	// reset hold timer
	logic                        cnt_done;	// top bit of timer
	logic                        boot_exit;	// firmware finished loading

	assign cnt_done = rst_cnt[`MM_RST_CNT_BITS-1];

	// only honoured while running with the overlay still on
	assign boot_exit = (state == seq_run) && boot && bootdone;

	//------------------------------
	// mrst synchronizer
	//------------------------------

	always_ff @(posedge clk)
	begin
		if (bootrst)
			mrst_s <= 1'b0;
		else
			mrst_s <= mrst;
	end

	//------------------------------
	// sequencer and timer
	//------------------------------

	always_ff @(posedge clk)
	begin
		if (bootrst)
		begin
			state   <= seq_hold;
			rst_cnt <= '0;
			boot    <= 1'b1;	// back to bootloader
		end
		else if (mrst_s || boot_exit)
		begin
			// any reset cause restarts the count
			state   <= seq_hold;
			rst_cnt <= '0;
			if (boot_exit)
				boot <= 1'b0;	// overlay off for good, mrst leaves it alone
		end
		else if (state == seq_hold)
		begin
			if (cnt_done)
				state <= seq_run;	// hold over
			else
				rst_cnt <= rst_cnt + 1'b1;
		end
	end

	// straight decode of the state flop
	assign sys_reset = (state == seq_hold);

endmodule

`default_nettype wire

// ==== verilog/bank_decoder.sv ====
/*
 * maps the bus region selects onto the four 512 KB sram blocks.
 * memcfg is latched while sys_reset is high; the request to the
 * bridge is combinational and forced idle during reset
 */
`default_nettype none

module bank_decoder
	import minimig_pkg::*;
(
	input  logic        clk,
	input  logic        sys_reset,
	input  logic        boot,	// kick area writable while set
	input  memcfg_e     memcfg,	// from the host, sampled in reset
	input  logic        sel_chip,	// chip ram region
	input  logic        sel_slow,	// slow ram region
	input  logic        sel_kick,	// kickstart region
	input  logic        addr19,	// upper/lower 512K of chip
	input  logic        rd,
	input  logic        hwr,
	input  logic        lwr,
	input  sram_data_t  wdata,
	sram_req_if.decoder req
);

	logic     extra_chip;	// second 512K of chip present
	logic     extra_slow;	// 512K slow ram present
	bank_en_t aen;	// raw block enables
	cyc_e     cyc;	// raw cycle kind
	logic     wr;	// any byte written

	//------------------------------
	// memory configuration latch
	//------------------------------

	// a config change only takes effect through a reset
	always_ff @(posedge clk)
	begin
		if (sys_reset)
		begin
			extra_chip <= memcfg[0];
			extra_slow <= memcfg[1];
		end
	end

	//------------------------------
	// block mapping
	//------------------------------

	always_comb
	begin
		aen = '0;
		aen[bank_chip_lo] = sel_chip & ~addr19;
		// slow region moves into chip_hi when there is no extra chip
		aen[bank_chip_hi] = (sel_chip & addr19 & extra_chip)
			| (sel_slow & ~extra_chip & extra_slow);
		aen[bank_slow] = sel_slow & extra_chip & extra_slow;
		aen[bank_kick] = sel_kick & (boot | rd);	// rom unless booting
	end

	// cycle kind, read wins (master never mixes them anyway)
	assign wr = hwr | lwr;

	always_comb
	begin
		if (rd)
			cyc = cyc_read;
		else if (wr)
			cyc = cyc_write;
		else
			cyc = cyc_idle;
	end

	//------------------------------
	// request to the bridge
	//------------------------------

	always_comb
	begin
		req.aen = '0;
		req.cyc = cyc_idle;
		req.hwr = 1'b0;
		req.lwr = 1'b0;
		// unaddressed or no strobe -> idle, so no bank select either
		if (!sys_reset && (aen != '0) && (cyc != cyc_idle))
		begin
			req.aen = aen;
			req.cyc = cyc;
			req.hwr = hwr & (cyc == cyc_write);
			req.lwr = lwr & (cyc == cyc_write);
		end
	end

	assign req.wdata = wdata;	// qualified by cyc at the bridge

endmodule

`default_nettype wire

// ==== verilog/sram_bridge.sv ====
/*
 * sram strobe bridge: two banks of 1 MB, bank selects and a19 from
 * the block enables, byte lanes, output enable, write pulse and data
 * drive enable. read data returns as zero when not addressed
 */
`default_nettype none

module sram_bridge
	import minimig_pkg::*;
(
	input  logic       clk,
	sram_req_if.bridge req,
	output logic       ram_sel0_n,	// bank 0, chip
	output logic       ram_sel1_n,	// bank 1, slow and kick
	output logic       ram_a19,	// upper half of a bank
	output logic       ram_ub_n,	// upper byte lane
	output logic       ram_lb_n,	// lower byte lane
	output logic       ram_we_n,
	output logic       ram_oe_n,
	output logic       ram_drive,	// data pads drive ram_wdata
	output sram_data_t ram_wdata,
	input  sram_data_t ram_rdata,
	output sram_data_t rdata	// back to the bus
);

	logic enable;	// some block addressed
	logic rd_cyc;
	logic wr_cyc;
	logic phase;	// write pulse timing

	assign enable = |req.aen;
	assign rd_cyc = enable && (req.cyc == cyc_read);
	assign wr_cyc = enable && (req.cyc == cyc_write);

	//------------------------------
	// bank mapping
	//------------------------------

	// chip_lo/chip_hi share bank 0, slow/kick share bank 1
	assign ram_sel0_n = ~(req.aen[bank_chip_lo] | req.aen[bank_chip_hi]);
	assign ram_sel1_n = ~(req.aen[bank_slow] | req.aen[bank_kick]);
	assign ram_a19    = req.aen[bank_chip_hi] | req.aen[bank_kick];	// odd blocks

	//------------------------------
	// strobes
	//------------------------------

	assign ram_oe_n = ~rd_cyc;
	assign ram_ub_n = ~(rd_cyc | (wr_cyc & req.hwr));	// reads take both lanes
	assign ram_lb_n = ~(rd_cyc | (wr_cyc & req.lwr));

	// toggles each clk, parked at 0 while idle so every two cycle
	// access starts on phase 0 and the pulse lands in its 2nd cycle
	always_ff @(posedge clk)
	begin
		if (req.cyc == cyc_idle)
			phase <= 1'b0;
		else
			phase <= ~phase;
	end

	assign ram_we_n = ~(wr_cyc & phase);	// one low cycle per write

	// drive for the whole access, covers we_n on both edges
	assign ram_drive = wr_cyc;
	assign ram_wdata = req.wdata;

	//------------------------------
	// read return
	//------------------------------

	assign rdata = rd_cyc ? ram_rdata : '0;	// zero lets the bus OR sources

endmodule

`default_nettype wire

// ==== verilog/minimig_mem.sv ====
/*
 * top of the memory and system-control core. plain ports toward the
 * bus master and the two sram banks; wires the sequencer, the bank
 * decoder and the strobe bridge together
 */
`default_nettype none

module minimig_mem
	import minimig_pkg::*;
(
	input  logic       clk,
	input  logic       bootrst,	// reset to bootloader
	input  logic       mrst,	// user/keyboard reset
	input  logic       bootdone,	// boot firmware finished
	input  memcfg_e    memcfg,
	input  logic       sel_chip,
	input  logic       sel_slow,
	input  logic       sel_kick,
	input  logic       addr19,
	input  logic       rd,
	input  logic       hwr,
	input  logic       lwr,
	input  sram_data_t wdata,
	input  sram_data_t ram_rdata,
	output logic       sys_reset,
	output logic       boot,
	output logic       ram_sel0_n,
	output logic       ram_sel1_n,
	output logic       ram_a19,
	output logic       ram_ub_n,
	output logic       ram_lb_n,
	output logic       ram_we_n,
	output logic       ram_oe_n,
	output logic       ram_drive,
	output sram_data_t ram_wdata,
	output sram_data_t rdata
);

	sram_req_if req_if ();	// decoded request

	//------------------------------
	// reset and boot sequencing
	//------------------------------

	sys_control u_sys_control
	(
		.clk       (clk),
		.bootrst   (bootrst),
		.mrst      (mrst),
		.bootdone  (bootdone),
		.sys_reset (sys_reset),
		.boot      (boot)
	);

	//------------------------------
	// memory path
	//------------------------------

	bank_decoder u_bank_decoder
	(
		.clk       (clk),
		.sys_reset (sys_reset),
		.boot      (boot),
		.memcfg    (memcfg),
		.sel_chip  (sel_chip),
		.sel_slow  (sel_slow),
		.sel_kick  (sel_kick),
		.addr19    (addr19),
		.rd        (rd),
		.hwr       (hwr),
		.lwr       (lwr),
		.wdata     (wdata),
		.req       (req_if.decoder)
	);

	sram_bridge u_sram_bridge
	(
		.clk        (clk),
		.req        (req_if.bridge),
		.ram_sel0_n (ram_sel0_n),
		.ram_sel1_n (ram_sel1_n),
		.ram_a19    (ram_a19),
		.ram_ub_n   (ram_ub_n),
		.ram_lb_n   (ram_lb_n),
		.ram_we_n   (ram_we_n),
		.ram_oe_n   (ram_oe_n),
		.ram_drive  (ram_drive),
		.ram_wdata  (ram_wdata),
		.ram_rdata  (ram_rdata),
		.rdata      (rdata)
	);

endmodule

`default_nettype wire

// ==== testbench/minimig_mem_chk.sv ====
/*
 * concurrent checks on the sram strobes of the memory core
 * bound into minimig_mem, nothing to instantiate by hand
 */
`default_nettype none

module minimig_mem_chk
(
	input logic clk,
	input logic sys_reset,
	input logic ram_sel0_n,
	input logic ram_sel1_n,
	input logic ram_ub_n,
	input logic ram_lb_n,
	input logic ram_we_n,
	input logic ram_oe_n,
	input logic ram_drive
);

	//------------------------------
	// strobe rules
	//------------------------------

	// only one bank per access
	bank_excl: assert property (@(posedge clk) !(!ram_sel0_n && !ram_sel1_n))
		else $error("both sram banks selected together");

	we_drive: assert property (@(posedge clk) !ram_we_n |-> ram_drive)	// pads must drive
		else $error("ram_we_n low without data drive");

	oe_we_excl: assert property (@(posedge clk) !(!ram_oe_n && !ram_we_n))
		else $error("ram_oe_n and ram_we_n low together");

	// everything parked while in reset
	quiet_reset: assert property (@(posedge clk) sys_reset |-> (ram_sel0_n && ram_sel1_n
		&& ram_ub_n && ram_lb_n && ram_we_n && ram_oe_n && !ram_drive))
		else $error("sram strobe active during sys_reset");

endmodule

bind minimig_mem minimig_mem_chk u_chk
(
	.clk        (clk),
	.sys_reset  (sys_reset),
	.ram_sel0_n (ram_sel0_n),
	.ram_sel1_n (ram_sel1_n),
	.ram_ub_n   (ram_ub_n),
	.ram_lb_n   (ram_lb_n),
	.ram_we_n   (ram_we_n),
	.ram_oe_n   (ram_oe_n),
	.ram_drive  (ram_drive)
);

`default_nettype wire

// ==== testbench/tb_minimig_mem.sv ====
/*
 * testbench for the memory core: reset and boot sequencing, then
 * random two-cycle bus accesses for every memory configuration,
 * checked cycle by cycle against a model of the mapping rules
 */
`default_nettype none

`include "minimig_defs.svh"

module tb_minimig_mem
	import minimig_pkg::*;
();

	localparam int HOLD_MIN     = 1 << (`MM_RST_CNT_BITS-1);
	localparam int HOLD_MAX     = HOLD_MIN + 3;
	localparam int NUM_HOLD_ACC = 8;	// accesses while held in reset
	localparam int NUM_ACC      = 64;	// accesses per config in run
	localparam int WATCH        = 8;
	localparam int CFG_CYCLES   = 3 + 2*NUM_HOLD_ACC + HOLD_MAX + 1 + 2*NUM_ACC;
	localparam int TEST_CYCLES  = 8 + 3*(HOLD_MAX + 4) + 8*CFG_CYCLES + WATCH + 4;
	localparam int MAX_CYCLES   = TEST_CYCLES + TEST_CYCLES/4 + 50;

	logic clk, bootrst, mrst, bootdone;
	memcfg_e memcfg;
	logic sel_chip, sel_slow, sel_kick, addr19, rd, hwr, lwr;
	sram_data_t wdata, ram_rdata, ram_wdata, rdata;
	logic sys_reset, boot, ram_sel0_n, ram_sel1_n, ram_a19;
	logic ram_ub_n, ram_lb_n, ram_we_n, ram_oe_n, ram_drive;

	integer seed;
	int cycles;
	int seq_errs, bank_errs, strobe_errs, data_errs;
	logic m_boot, m_reset, m_xchip, m_xslow;	// model state

	minimig_mem dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//------------------------------
	// compare tasks
	//------------------------------

	task automatic check_seq(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			seq_errs++;
			$display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bank(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			bank_errs++;
			$display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_strobes(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			strobe_errs++;
			$display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_data(input string name, input sram_data_t got, input sram_data_t exp);
		if (got !== exp)
		begin
			data_errs++;
			$display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	//------------------------------
	// model and helpers
	//------------------------------

	function automatic int rand_below(input int n);
		int unsigned r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	// region 1 chip, 2 slow, 3 kick, 0 nothing
	function automatic bank_en_t expected_enables(input int region, input logic a19,
		input logic rd_v, input logic wr_v);
		bank_en_t en;
		en = '0;
		if (m_reset || !(rd_v || wr_v))
			return en;	// held or idle
		case (region)
			1: if (!a19) en[bank_chip_lo] = 1'b1;
				else if (m_xchip) en[bank_chip_hi] = 1'b1;
			2: if (m_xchip && m_xslow) en[bank_slow] = 1'b1;
				else if (!m_xchip && m_xslow) en[bank_chip_hi] = 1'b1;	// slow in chip_hi
			3: if (m_boot || rd_v) en[bank_kick] = 1'b1;	// rom once booted
			default: ;
		endcase
		return en;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_idle();
		sel_chip = 1'b0;
		sel_slow = 1'b0;
		sel_kick = 1'b0;
		rd = 1'b0;
		hwr = 1'b0;
		lwr = 1'b0;
	endtask

	// n = edges since the last reset cause, release must land in window
	task automatic measure_hold(input int start, input logic exp_boot);
		int n;
		logic released;
		n = start;
		released = 1'b0;
		while (!released && n <= HOLD_MAX)
		begin
			@(negedge clk);
			check_seq("boot", boot, exp_boot);
			if (sys_reset !== 1'b1)
				released = 1'b1;
			else
			begin
				step();
				n++;
			end
		end
		if (!released || n < HOLD_MIN)
		begin
			seq_errs++;
			$display("sys_reset released after %0d cycles, expected %0d to %0d",
				n, HOLD_MIN, HOLD_MAX);
		end
		step();
	endtask

	task automatic wait_seq(input logic exp_rst, input logic exp_boot, input int limit,
		output int n);
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n <= limit)
		begin
			@(negedge clk);
			seen = (sys_reset === exp_rst) && (boot === exp_boot);
			step();
			n++;
		end
		if (!seen)
		begin
			seq_errs++;
			$display("sys_reset and boot did not reach %b and %b in time", exp_rst, exp_boot);
		end
	endtask

	task automatic watch_seq(input int n, input logic exp_rst, input logic exp_boot);
		repeat (n)
		begin
			@(negedge clk);
			check_seq("sys_reset", sys_reset, exp_rst);
			check_seq("boot", boot, exp_boot);
			step();
		end
	endtask

	task automatic pulse_mrst();
		mrst = 1'b1;
		step();
		mrst = 1'b0;
	endtask

	// one random access held for two cycles
	task automatic do_access();
		int region, kind, lanes, cyc;
		logic [31:0] rw, rr;
		logic a19_v, rd_v, hwr_v, lwr_v, rd_act, wr_act;
		bank_en_t en;
		sram_data_t exp_rd;
		region = rand_below(4);
		kind = rand_below(8);	// 0 idle, 1..3 read, 4..7 write
		lanes = rand_below(3) + 1;
		rw = $random(seed);
		rr = $random(seed);
		a19_v = rw[31];
		rd_v = (kind >= 1) && (kind <= 3);
		hwr_v = (kind >= 4) && ((lanes & 2) != 0);
		lwr_v = (kind >= 4) && ((lanes & 1) != 0);
		sel_chip = (region == 1);
		sel_slow = (region == 2);
		sel_kick = (region == 3);
		addr19 = a19_v;
		rd = rd_v;
		hwr = hwr_v;
		lwr = lwr_v;
		wdata = rw[`MM_DATA_BITS-1:0];
		ram_rdata = rr[`MM_DATA_BITS-1:0];
		en = expected_enables(region, a19_v, rd_v, hwr_v || lwr_v);
		rd_act = (en != '0) && rd_v;
		wr_act = (en != '0) && (hwr_v || lwr_v);
		exp_rd = rd_act ? rr[`MM_DATA_BITS-1:0] : '0;	// zero when not addressed
		for (cyc = 0; cyc < 2; cyc++)
		begin
			@(negedge clk);
			check_bank("ram_sel0_n", ram_sel0_n, !(en[bank_chip_lo] || en[bank_chip_hi]));
			check_bank("ram_sel1_n", ram_sel1_n, !(en[bank_slow] || en[bank_kick]));
			check_bank("ram_a19", ram_a19, en[bank_chip_hi] || en[bank_kick]);
			check_strobes("ram_oe_n", ram_oe_n, !rd_act);
			check_strobes("ram_ub_n", ram_ub_n, !(rd_act || (wr_act && hwr_v)));
			check_strobes("ram_lb_n", ram_lb_n, !(rd_act || (wr_act && lwr_v)));
			check_strobes("ram_we_n", ram_we_n, !(wr_act && cyc == 1));	// 2nd cycle only
			check_strobes("ram_drive", ram_drive, wr_act);
			check_data("rdata", rdata, exp_rd);
			if (wr_act)
				check_data("ram_wdata", ram_wdata, rw[`MM_DATA_BITS-1:0]);
			step();
		end
		bus_idle();
	endtask

	// latch cfg through an mrst, poke the bus in hold, then run
	task automatic run_config(input memcfg_e cfg);
		memcfg = cfg;
		m_xchip = (cfg == mem_chip1m) || (cfg == mem_chip1m_slow512);
		m_xslow = (cfg == mem_chip512_slow512) || (cfg == mem_chip1m_slow512);
		pulse_mrst();
		step();
		m_reset = 1'b1;
		repeat (NUM_HOLD_ACC) do_access();
		measure_hold(1 + 2*NUM_HOLD_ACC, m_boot);
		m_reset = 1'b0;
		memcfg = cfg.next();	// must not reach the latch
		repeat (NUM_ACC) do_access();
	endtask

	//------------------------------
	// test sequence
	//------------------------------

	initial
	begin
		memcfg_e cfg;
		int n;
		seed = 32'hc224_3309;
		cycles = 0;
		seq_errs = 0;
		bank_errs = 0;
		strobe_errs = 0;
		data_errs = 0;
		bootrst = 1'b1;
		mrst = 1'b0;
		bootdone = 1'b0;
		memcfg = mem_chip1m_slow512;
		addr19 = 1'b0;
		wdata = '0;
		ram_rdata = '0;
		bus_idle();
		m_boot = 1'b1;
		m_reset = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		bootrst = 1'b0;
		measure_hold(0, 1'b1);	// power-up hold, overlay on

		// mrst restart, bootdone inside the hold is ignored
		pulse_mrst();
		step();
		bootdone = 1'b1;
		step();
		bootdone = 1'b0;
		measure_hold(2, 1'b1);
		m_reset = 1'b0;

		cfg = mem_chip512;
		repeat (4)
		begin
			run_config(cfg);
			cfg = cfg.next();
		end

		// firmware done: overlay off and a fresh hold
		bootdone = 1'b1;
		step();
		bootdone = 1'b0;
		m_boot = 1'b0;
		wait_seq(1'b1, 1'b0, 2, n);
		measure_hold(n, 1'b0);
		bootdone = 1'b1;	// overlay already off
		step();
		bootdone = 1'b0;
		watch_seq(WATCH, 1'b0, 1'b0);

		repeat (4)
		begin
			run_config(cfg);
			cfg = cfg.next();
		end

		$display("error counts: seq %0d bank %0d strobe %0d data %0d",
			seq_errs, bank_errs, strobe_errs, data_errs);
		if (seq_errs + bank_errs + strobe_errs + data_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== minimig_mem.f ====
+incdir+verilog
verilog/minimig_pkg.sv
verilog/sram_req_if.sv
verilog/sys_control.sv
verilog/bank_decoder.sv
verilog/sram_bridge.sv
verilog/minimig_mem.sv
testbench/minimig_mem_chk.sv
testbench/tb_minimig_mem.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_minimig_mem
FILELIST = minimig_mem.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
